// ==== filelist.f ====
wb_host_pkg.sv
wb_clk_div.sv
wb_host_regs.sv
wb_host_path.sv
wb_host.sv
tb_wb_host.sv

// ==== tb_wb_host.sv ====
// ----------------------------------------
// wishbone host testbench: master tasks,
// slave model with lfsr waits, checks
// ----------------------------------------
`timescale 1ns/1ps

module tb_wb_host;

   localparam int CLK_HALF  = 20;     // 40 ns period
   localparam int DRV_DLY   = 2;      // drive after rising edge
   localparam int ACK_LIMIT = 20;     // cycles allowed per access
   localparam int RUN_LIMIT = 2000;   // whole run, in clocks

   logic                          clk;
   logic                          rst_n;
   wb_host_pkg::wb_req_t          mst_req;
   wb_host_pkg::wb_rsp_t          mst_rsp;
   wb_host_pkg::wb_req_t          slv_req;
   wb_host_pkg::wb_rsp_t          slv_rsp;
   logic                          clk_out;
   logic                          wbd_rst_n;
   logic                          bist_rst_n;
   logic [31:0]                   ctrl1;
   logic [31:0]                   ctrl2;
   logic [31:0]                   lfsr = 32'h8dda_f3ff;
   logic [31:0]                   glb_shadow;    // expected register 0
   logic [7:0]                    bank_shadow;   // expected bank
   int                            slv_waits;     // wait states of last slave access
   int                            cycle_cnt = 0;
   int                            err_cnt;
   int                            test_cnt;
   int                            test_fail;
   int                            test_err0;     // err_cnt at test start
   string                         test_name;

   wb_host dut_i (
      .wbm_clk_i        (clk),
      .wbm_rst_n        (rst_n),
      .wbm_req_i        (mst_req),
      .wbm_rsp_o        (mst_rsp),
      .wbs_req_o        (slv_req),
      .wbs_rsp_i        (slv_rsp),
      .wbs_clk_out_o    (clk_out),
      .wbd_int_rst_n_o  (wbd_rst_n),
      .bist_rst_n_o     (bist_rst_n),
      .cfg_clk_ctrl1_o  (ctrl1),
      .cfg_clk_ctrl2_o  (ctrl2)
   );

   initial
   begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= RUN_LIMIT)
      begin
         $display("run stopped after %0d clock cycles without finishing", RUN_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // byte lanes of dat replace old where sel is set
   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] r;
      r = old;
      for (int b = 0; b < 4; b++)
      begin
         if (sel[b])
            r[8*b +: 8] = dat[8*b +: 8];
      end
      return r;
   endfunction

   function automatic logic [31:0] reg_adr(input logic [1:0] idx);
      return (32'h1 << wb_host_pkg::REG_SEL_BIT) | (idx << wb_host_pkg::REG_IDX_LSB);
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      a_value: assert (got === exp)
      else
      begin
         err_cnt++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_err0 = err_cnt;
      test_cnt++;
   endtask

   task automatic report_test();
      if (err_cnt == test_err0)
         $display("test %0d %s: passed", test_cnt, test_name);
      else
      begin
         test_fail++;
         $display("test %0d %s: failed, %0d errors", test_cnt, test_name, err_cnt - test_err0);
      end
   endtask

   // ----------------------------------------
   // master side
   // ----------------------------------------
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdat,
                             output logic err, output int lat);
      @(posedge clk);
      #DRV_DLY;
      mst_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
      lat = 0;
      do
      begin
         @(posedge clk);
         #1;                                 // outputs settled
         lat++;
      end
      while (!mst_rsp.ack && lat < ACK_LIMIT);
      rdat = mst_rsp.dat;
      err  = mst_rsp.err;
      if (!mst_rsp.ack)
      begin
         err_cnt++;
         $display("no ack from the DUT within %0d cycles, adr %h", ACK_LIMIT, adr);
      end
      @(posedge clk);                        // hold through the ack cycle
      #DRV_DLY;
      mst_req = '0;
   endtask

   task automatic write_reg(input logic [1:0] idx, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] rdat;
      logic        err;
      int          lat;
      bus_access(1'b1, reg_adr(idx), dat, sel, rdat, err, lat);
      check_equal("register ack latency", lat, 3);   // third edge after stb
      check_equal("wbm_rsp_o.err", err, 0);
   endtask

   task automatic read_reg(input logic [1:0] idx, input logic [31:0] exp, input string name);
      logic [31:0] rdat;
      logic        err;
      int          lat;
      bus_access(1'b0, reg_adr(idx), '0, 4'hf, rdat, err, lat);
      check_equal("register ack latency", lat, 3);
      check_equal("wbm_rsp_o.err", err, 0);
      check_equal(name, rdat, exp);
   endtask

   // ----------------------------------------
   // slave model, 0 to 3 wait states
   // ----------------------------------------
   initial
   begin : slave_model
      logic [31:0] w;
      slv_rsp = '0;
      forever
      begin
         @(posedge clk);
         #1;
         if (slv_req.stb)
         begin
            rand_bits(2, w);
            slv_waits = w;
            for (int k = 0; k < slv_waits; k++)
            begin
               @(posedge clk);
               #1;
            end
            #1;
            slv_rsp = '{dat: ~slv_req.adr, ack: 1'b1, err: slv_req.adr[4]};
            @(posedge clk);
            #DRV_DLY;
            slv_rsp.ack = 1'b0;                // single-cycle ack
            slv_rsp.err = 1'b0;
         end
      end
   end

   // ----------------------------------------
   // bus assertions
   // ----------------------------------------
   a_reg_no_slave: assert property (@(posedge clk) disable iff (!rst_n)
      (mst_req.stb && mst_req.adr[wb_host_pkg::REG_SEL_BIT]) |-> !slv_req.stb)
   else
   begin
      err_cnt++;
      $display("%0t ns: a register access raised the slave strobe", $time);
   end

   a_slv_adr: assert property (@(posedge clk) disable iff (!rst_n)
      slv_req.stb |-> slv_req.adr == {bank_shadow, mst_req.adr[wb_host_pkg::BANK_LSB-1:0]})
   else
   begin
      err_cnt++;
      $display("** Error at %0t ns: wbs_req_o.adr is %h, expected %h", $time,
               $sampled(slv_req.adr), {bank_shadow, $sampled(mst_req.adr[23:0])});
   end

   a_slv_fields: assert property (@(posedge clk) disable iff (!rst_n)
      slv_req.stb |-> slv_req.cyc && slv_req.we == mst_req.we &&
                      slv_req.dat == mst_req.dat && slv_req.sel == mst_req.sel)
   else
   begin
      err_cnt++;
      $display("%0t ns: cyc, we, dat or sel wrong on the way to the slave", $time);
   end

   // master sees slave data and err one cycle later, slave strobe drops
   a_slv_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      slv_rsp.ack |=> mst_rsp.ack && !slv_req.stb && mst_rsp.dat == $past(slv_rsp.dat) &&
                      mst_rsp.err == $past(slv_rsp.err))
   else
   begin
      err_cnt++;
      $display("%0t ns: slave response not passed to the master one cycle later", $time);
   end

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic test_after_reset();
      begin_test("after reset");
      check_equal("wbm_rsp_o.ack", mst_rsp.ack, 0);
      check_equal("wbm_rsp_o.err", mst_rsp.err, 0);
      check_equal("wbs_req_o.stb", slv_req.stb, 0);
      check_equal("wbd_int_rst_n_o", wbd_rst_n, 0);
      check_equal("bist_rst_n_o", bist_rst_n, 0);
      @(negedge clk);
      #1;
      check_equal("wbs_clk_out_o", clk_out, clk);
      @(posedge clk);
      #1;
      check_equal("wbs_clk_out_o", clk_out, clk);
      for (int i = 0; i < 4; i++)
         read_reg(i, 32'h0, "register readback");
      report_test();
   endtask

   task automatic test_glb_bytes();
      begin_test("global register byte selects");
      write_reg(wb_host_pkg::REG_GLB, 32'hA5A5_A5A5, 4'b0101);   // bytes 0 and 2
      glb_shadow = merge_bytes(glb_shadow, 32'hA5A5_A5A5, 4'b0101);
      read_reg(wb_host_pkg::REG_GLB, glb_shadow, "glb readback");
      check_equal("wbd_int_rst_n_o", wbd_rst_n, glb_shadow[0]);
      check_equal("bist_rst_n_o", bist_rst_n, glb_shadow[1]);
      write_reg(wb_host_pkg::REG_GLB, 32'h5A5A_5A02, 4'b1001);   // flips both resets
      glb_shadow = merge_bytes(glb_shadow, 32'h5A5A_5A02, 4'b1001);
      read_reg(wb_host_pkg::REG_GLB, glb_shadow, "glb readback");
      check_equal("wbd_int_rst_n_o", wbd_rst_n, glb_shadow[0]);
      check_equal("bist_rst_n_o", bist_rst_n, glb_shadow[1]);
      report_test();
   endtask

   task automatic test_bank_clk();
      begin_test("bank and clock words");
      write_reg(wb_host_pkg::REG_BANK, 32'h1234_56C3, 4'hf);
      bank_shadow = 8'hC3;                   // low byte only
      read_reg(wb_host_pkg::REG_BANK, {24'h0, bank_shadow}, "bank readback");
      write_reg(wb_host_pkg::REG_CLK1, 32'hDEAD_BEEF, 4'b0001);   // sel ignored
      write_reg(wb_host_pkg::REG_CLK2, 32'h0123_4567, 4'b0010);
      read_reg(wb_host_pkg::REG_CLK1, 32'hDEAD_BEEF, "clk ctrl1 readback");
      read_reg(wb_host_pkg::REG_CLK2, 32'h0123_4567, "clk ctrl2 readback");
      check_equal("cfg_clk_ctrl1_o", ctrl1, 32'hDEAD_BEEF);
      check_equal("cfg_clk_ctrl2_o", ctrl2, 32'h0123_4567);
      report_test();
   endtask

   task automatic test_slave();
      logic [31:0] adr;
      logic [31:0] dat;
      logic [31:0] r;
      logic [31:0] rdat;
      logic [31:0] seen;
      logic        err;
      int          lat;
      begin_test("slave access");
      for (int n = 0; n < 8; n++)
      begin
         rand_bits(32, adr);
         adr[wb_host_pkg::REG_SEL_BIT] = 1'b0;   // keep it off the registers
         rand_bits(32, dat);
         rand_bits(5, r);                        // sel and we
         bus_access(r[4], adr, dat, r[3:0], rdat, err, lat);
         seen = {bank_shadow, adr[wb_host_pkg::BANK_LSB-1:0]};
         check_equal("wbm_rsp_o.dat", rdat, ~seen);
         check_equal("wbm_rsp_o.err", err, seen[4]);
         check_equal("slave access latency", lat, slv_waits + 2);
      end
      report_test();
   endtask

   // high and low run lengths of the divided clock, in input cycles
   task automatic measure_div(output int hi, output int lo);
      int guard;
      guard = 0;
      hi = 0;
      lo = 0;
      @(posedge clk);
      #1;
      while (clk_out !== 1'b0 && guard < 40)
      begin
         @(posedge clk);
         #1;
         guard++;
      end
      while (clk_out !== 1'b1 && guard < 40)
      begin
         @(posedge clk);
         #1;
         guard++;
      end
      while (clk_out === 1'b1 && hi < 40)
      begin
         @(posedge clk);
         #1;
         hi++;
      end
      while (clk_out === 1'b0 && lo < 40)
      begin
         @(posedge clk);
         #1;
         lo++;
      end
   endtask

   task automatic divider_case(input logic [2:0] r);
      wb_host_pkg::host_glb_t g;
      int hi;
      int lo;
      g = glb_shadow;
      g.clk_div_en = 1'b1;
      g.clk_ratio  = r;
      write_reg(wb_host_pkg::REG_GLB, g, 4'hf);
      glb_shadow = g;
      measure_div(hi, lo);
      check_equal("wbs_clk_out_o high cycles", hi, r + 1);
      check_equal("wbs_clk_out_o low cycles", lo, r + 1);
   endtask

   task automatic test_divider();
      begin_test("clock divider");
      divider_case(3'd1);
      divider_case(3'd3);
      report_test();
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial
   begin
      mst_req     = '0;
      rst_n       = 1'b0;
      err_cnt     = 0;
      test_cnt    = 0;
      test_fail   = 0;
      glb_shadow  = '0;
      bank_shadow = '0;
      repeat (2) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;
      test_after_reset();
      test_glb_bytes();
      test_bank_clk();
      test_slave();
      test_divider();
      $display("tests run %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== wb_clk_div.sv ====
// ----------------------------------------
// downstream clock divider and clock select
// ----------------------------------------
`timescale 1ns/1ps

module wb_clk_div (
   input  logic                                 wbm_clk_i,
   input  logic                                 wbm_rst_n,
   input  logic [wb_host_pkg::DIV_RATIO_W-1:0]  ratio_i,    // half period minus 1
   input  logic                                 div_en_i,   // 1 selects divided clock
   output logic                                 wbs_clk_out_o
);

   // ----------------------------------------
   // local declarations
   // ----------------------------------------
   logic [wb_host_pkg::DIV_RATIO_W-1:0]  ratio_q;   // last seen ratio
   logic [wb_host_pkg::DIV_RATIO_W-1:0]  cnt_q;     // cycles in current half period
   logic                                 clk_div_q; // divided clock
   logic                                 ratio_chg;

   assign ratio_chg = (ratio_i != ratio_q);

   // ----------------------------------------
   // half-period counter
   // ----------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         ratio_q   <= '0;
         cnt_q     <= '0;
         clk_div_q <= 1'b0;
      end
      else if (ratio_chg)
      begin
         // new ratio, restart from low
         ratio_q   <= ratio_i;
         cnt_q     <= '0;
         clk_div_q <= 1'b0;
      end
      else if (cnt_q == ratio_q)
      begin
         cnt_q     <= '0;
         clk_div_q <= ~clk_div_q;   // toggle every ratio+1 cycles
      end
      else
      begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // ----------------------------------------
   // clock select
   // ----------------------------------------
   // div off -> straight input clock, as after reset
   assign wbs_clk_out_o = div_en_i ? clk_div_q : wbm_clk_i;

   // ----------------------------------------
   // assertions
   // ----------------------------------------
   // counter wraps at the ratio, even across a ratio change
   a_cnt_range: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      cnt_q <= ratio_q);

endmodule

// ==== wb_host.sv ====
// ----------------------------------------
// wishbone host top: request path, local
// registers, downstream clock divider
// ----------------------------------------
`timescale 1ns/1ps

module wb_host (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,

   // master port
   input  wb_host_pkg::wb_req_t            wbm_req_i,
   output wb_host_pkg::wb_rsp_t            wbm_rsp_o,

   // slave port
   output wb_host_pkg::wb_req_t            wbs_req_o,
   input  wb_host_pkg::wb_rsp_t            wbs_rsp_i,
   output logic                            wbs_clk_out_o,   // downstream clock

   // software controls
   output logic                            wbd_int_rst_n_o, // glb bit 0
   output logic                            bist_rst_n_o,    // glb bit 1
   output logic [wb_host_pkg::WB_DW-1:0]   cfg_clk_ctrl1_o,
   output logic [wb_host_pkg::WB_DW-1:0]   cfg_clk_ctrl2_o
);

   // ----------------------------------------
   // internal wires
   // ----------------------------------------
   wb_host_pkg::wb_req_t            reg_req;   // path -> regs
   wb_host_pkg::wb_rsp_t            reg_rsp;   // regs -> path
   wb_host_pkg::host_glb_t          glb;       // global control
   logic [wb_host_pkg::BANK_W-1:0]  bank;      // address bank

   // ----------------------------------------
   // request stage and response register
   // ----------------------------------------
   wb_host_path u_path (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .wbm_req_i  (wbm_req_i),
      .wbm_rsp_o  (wbm_rsp_o),
      .wbs_req_o  (wbs_req_o),
      .wbs_rsp_i  (wbs_rsp_i),
      .reg_req_o  (reg_req),
      .reg_rsp_i  (reg_rsp),
      .bank_i     (bank)
   );

   // ----------------------------------------
   // local registers
   // ----------------------------------------
   wb_host_regs u_regs (
      .wbm_clk_i    (wbm_clk_i),
      .wbm_rst_n    (wbm_rst_n),
      .reg_req_i    (reg_req),
      .reg_rsp_o    (reg_rsp),
      .glb_o        (glb),
      .bank_o       (bank),
      .clk_ctrl1_o  (cfg_clk_ctrl1_o),  // passed straight out
      .clk_ctrl2_o  (cfg_clk_ctrl2_o)
   );

   // ----------------------------------------
   // downstream clock
   // ----------------------------------------
   wb_clk_div u_clk_div (
      .wbm_clk_i      (wbm_clk_i),
      .wbm_rst_n      (wbm_rst_n),
      .ratio_i        (glb.clk_ratio),
      .div_en_i       (glb.clk_div_en),
      .wbs_clk_out_o  (wbs_clk_out_o)
   );

   // software resets for the user area, low after reset
   assign wbd_int_rst_n_o = glb.wb_rst_n;
   assign bist_rst_n_o    = glb.bist_rst_n;

endmodule

// ==== wb_host_path.sv ====
// ----------------------------------------
// request stage: local/slave select, bank
// address forming, registered response
// ----------------------------------------
`timescale 1ns/1ps

module wb_host_path (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,
   input  wb_host_pkg::wb_req_t            wbm_req_i,   // from external master
   output wb_host_pkg::wb_rsp_t            wbm_rsp_o,
   output wb_host_pkg::wb_req_t            wbs_req_o,   // to downstream slave
   input  wb_host_pkg::wb_rsp_t            wbs_rsp_i,
   output wb_host_pkg::wb_req_t            reg_req_o,   // to local registers
   input  wb_host_pkg::wb_rsp_t            reg_rsp_i,
   input  logic [wb_host_pkg::BANK_W-1:0]  bank_i
);

   // ----------------------------------------
   // local declarations
   // ----------------------------------------
   logic                            req_q;     // pending request, strobe delayed 1 cycle
   logic                            adr_loc;   // address hits local space
   logic                            loc_sel;   // local strobe
   logic                            slv_sel;   // slave strobe
   logic                            ack_int;   // unregistered ack, either side
   logic                            err_int;
   logic [wb_host_pkg::WB_DW-1:0]   dat_int;
   logic                            ack_q;
   logic                            err_q;
   logic [wb_host_pkg::WB_DW-1:0]   dat_q;     // last acknowledged data

   // ----------------------------------------
   // request split
   // ----------------------------------------
   assign adr_loc = wbm_req_i.adr[wb_host_pkg::REG_SEL_BIT];
   assign loc_sel = req_q & adr_loc;
   assign slv_sel = req_q & ~adr_loc;

   // register side sees the master request with its own strobe
   always_comb
   begin
      reg_req_o     = wbm_req_i;
      reg_req_o.stb = loc_sel;
   end

   // slave side, top byte swapped for the bank
   always_comb
   begin
      wbs_req_o     = wbm_req_i;
      wbs_req_o.cyc = wbm_req_i.cyc & ~adr_loc;
      wbs_req_o.stb = slv_sel;
      wbs_req_o.adr = {bank_i, wbm_req_i.adr[wb_host_pkg::BANK_LSB-1:0]};
   end

   // ----------------------------------------
   // response select
   // ----------------------------------------
   // gate by the active side so a stray ack is ignored
   assign ack_int = (loc_sel & reg_rsp_i.ack) | (slv_sel & wbs_rsp_i.ack);
   assign err_int = slv_sel & wbs_rsp_i.err;            // local never errors
   assign dat_int = loc_sel ? reg_rsp_i.dat : wbs_rsp_i.dat;

   // ----------------------------------------
   // pending flag and registered response
   // ----------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         req_q <= 1'b0;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         // no new request while either ack is up
         req_q <= wbm_req_i.cyc & wbm_req_i.stb & ~ack_q & ~ack_int;
         ack_q <= ack_int;
         err_q <= err_int;
      end
   end

   // hold data between accesses
   always_ff @(posedge wbm_clk_i)
   begin
      if (ack_int)
         dat_q <= dat_int;
   end

   always_comb
   begin
      wbm_rsp_o.dat = dat_q;
      wbm_rsp_o.ack = ack_q;
      wbm_rsp_o.err = err_q;
   end

   // ----------------------------------------
   // assertions
   // ----------------------------------------
   // one target per access, the strobe never hops sides
   a_sel_onehot: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !((reg_req_o.stb || $past(reg_req_o.stb)) &&
        (wbs_req_o.stb || $past(wbs_req_o.stb))));

endmodule

// ==== wb_host_pkg.sv ====
// ----------------------------------------
// wishbone host package: address map,
// register indices, bus and control structs
// ----------------------------------------
package wb_host_pkg;

   // ----------------------------------------
   // bus widths
   // ----------------------------------------
   localparam int WB_AW = 32;   // address width
   localparam int WB_DW = 32;   // data width
   localparam int WB_SW = 4;    // byte selects

   // ----------------------------------------
   // address map
   // ----------------------------------------
   // adr[23] set -> local register space, else downstream slave
   localparam int REG_SEL_BIT = 23;

   // top byte of forwarded address comes from the bank register
   localparam int BANK_W   = 8;
   localparam int BANK_LSB = 24;

   // register index sits in adr[3:2], word aligned
   localparam int REG_IDX_LSB = 2;

   localparam logic [1:0] REG_GLB  = 2'd0;  // global control
   localparam logic [1:0] REG_BANK = 2'd1;  // address bank
   localparam logic [1:0] REG_CLK1 = 2'd2;  // clock control word 1
   localparam logic [1:0] REG_CLK2 = 2'd3;  // clock control word 2

   localparam int DIV_RATIO_W = 3;  // downstream clock divider ratio

   // ----------------------------------------
   // bus structs
   // ----------------------------------------
   // wishbone classic request, master side
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic [WB_SW-1:0] sel;
   } wb_req_t;

   // wishbone classic response
   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
      logic             err;
   } wb_rsp_t;

   // register 0 layout, msb first
   typedef struct packed {
      logic [19:0]            spare_hi;    // bits 31:12
      logic                   clk_div_en;  // bit 11, use divided clock
      logic [DIV_RATIO_W-1:0] clk_ratio;   // bits 10:8
      logic [5:0]             spare_lo;    // bits 7:2
      logic                   bist_rst_n;  // bit 1
      logic                   wb_rst_n;    // bit 0
   } host_glb_t;

endpackage

// ==== wb_host_regs.sv ====
// ----------------------------------------
// local register block: decode, global,
// bank and clock-control registers, read mux
// ----------------------------------------
`timescale 1ns/1ps

module wb_host_regs (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,
   input  wb_host_pkg::wb_req_t            reg_req_i,    // stb is the local select
   output wb_host_pkg::wb_rsp_t            reg_rsp_o,
   output wb_host_pkg::host_glb_t          glb_o,
   output logic [wb_host_pkg::BANK_W-1:0]  bank_o,
   output logic [wb_host_pkg::WB_DW-1:0]   clk_ctrl1_o,
   output logic [wb_host_pkg::WB_DW-1:0]   clk_ctrl2_o
);

   // ----------------------------------------
   // local declarations
   // ----------------------------------------
   logic [1:0]                      reg_idx;    // word index from adr[3:2]
   logic                            wr_en;      // write, first cycle only
   logic                            rd_en;      // read, first cycle only
   logic [wb_host_pkg::WB_DW-1:0]   rd_mux;
   logic [wb_host_pkg::WB_DW-1:0]   rd_dat_q;   // captured read data
   logic                            ack_q;

   wb_host_pkg::host_glb_t          glb_q;
   logic [wb_host_pkg::BANK_W-1:0]  bank_q;
   logic [wb_host_pkg::WB_DW-1:0]   ctrl1_q;
   logic [wb_host_pkg::WB_DW-1:0]   ctrl2_q;

   // ----------------------------------------
   // decode
   // ----------------------------------------
   assign reg_idx = reg_req_i.adr[wb_host_pkg::REG_IDX_LSB +: 2];

   // strobe stays up through the ack cycle, so block the repeat
   assign wr_en = reg_req_i.stb & reg_req_i.we & ~ack_q;
   assign rd_en = reg_req_i.stb & ~reg_req_i.we & ~ack_q;

   // single-cycle ack per access
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         ack_q <= 1'b0;
      else
         ack_q <= reg_req_i.stb & ~ack_q;
   end

   // ----------------------------------------
   // register writes
   // ----------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_q   <= '0;   // both reset outputs held low
         bank_q  <= '0;
         ctrl1_q <= '0;
         ctrl2_q <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx)
            wb_host_pkg::REG_GLB:
            begin
               // byte lanes under sel
               for (int b = 0; b < wb_host_pkg::WB_SW; b++)
               begin
                  if (reg_req_i.sel[b])
                     glb_q[8*b +: 8] <= reg_req_i.dat[8*b +: 8];
               end
            end
            wb_host_pkg::REG_BANK:
               bank_q <= reg_req_i.dat[wb_host_pkg::BANK_W-1:0];  // low byte only
            wb_host_pkg::REG_CLK1:
               ctrl1_q <= reg_req_i.dat;   // full word, sel ignored
            default:
               ctrl2_q <= reg_req_i.dat;   // REG_CLK2
         endcase
      end
   end

   // ----------------------------------------
   // read path
   // ----------------------------------------
   always_comb
   begin
      case (reg_idx)
         wb_host_pkg::REG_GLB:  rd_mux = glb_q;
         wb_host_pkg::REG_BANK:
            rd_mux = {{(wb_host_pkg::WB_DW - wb_host_pkg::BANK_W){1'b0}}, bank_q};
         wb_host_pkg::REG_CLK1: rd_mux = ctrl1_q;
         default:               rd_mux = ctrl2_q;
      endcase
   end

   // data lines up with ack
   always_ff @(posedge wbm_clk_i)
   begin
      if (rd_en)
         rd_dat_q <= rd_mux;
   end

   always_comb
   begin
      reg_rsp_o.dat = rd_dat_q;
      reg_rsp_o.ack = ack_q;
      reg_rsp_o.err = 1'b0;        // local space never errors
   end

   assign glb_o       = glb_q;
   assign bank_o      = bank_q;
   assign clk_ctrl1_o = ctrl1_q;
   assign clk_ctrl2_o = ctrl2_q;

   // ----------------------------------------
   // assertions
   // ----------------------------------------
   // strobe gone the cycle after ack, so no second ack
   a_ack_pulse: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      ack_q |=> !ack_q && !reg_req_i.stb);

   // ack answers a fresh strobe, one cycle after it rose
   a_ack_after_stb: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      ack_q |-> $past(reg_req_i.stb) && !$past(reg_req_i.stb, 2));

endmodule
